// ==== compile.f ====
blob_pkg.sv
run_intake.sv
run_labeler.sv
object_table.sv
report_writer.sv
blob_detector.sv
tb_blob_detector.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_blob_detector -o sim_blob; then
  echo "verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/sim_blob 2>&1); then
  printf '%s\n' "$output"
  echo "simulation exited with an error"
  exit 1
fi
printf '%s\n' "$output"

if grep -qx "=== PASS ===" <<< "$output"; then
  exit 0
fi
exit 1

// ==== tb_blob_detector.sv ====
`timescale 1ns/1ns

module tb_blob_detector import blob_pkg::*; ();

  logic               clk;
  logic               rst;
  logic               in_valid;
  logic [TOKEN_W-1:0] in_token;
  logic               in_credit;
  logic               out_valid;
  logic [WORD_W-1:0]  out_data;
  logic               out_last;
  logic               out_credit = 1'b0;

  logic [TOKEN_W-1:0] tok_q [$];
  logic [WORD_W-1:0]  exp_q [$];
  bit                 last_q [$];
  int                 ret_q [$];  // cycles at which the sink hands credit back
  logic [WORD_W-1:0]  exp_w;
  bit                 exp_l;

  int    words_exp = 0;
  int    words_seen = 0;
  int    tok_sent = 0;
  int    credit_back = 0;
  int    out_cred = OUT_CREDITS;  // mirror of the DUT output credit
  int    sink_delay = 0;
  int    cyc = 0;
  int    limit = 2000;
  int    err_cnt = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  string cur_test = "reset";
  string wait_what = "reset";
  logic [31:0] rnd_state = 32'd41678;

  // reference model state
  int m_prev_s [MAX_RUNS];
  int m_prev_e [MAX_RUNS];
  int m_prev_l [MAX_RUNS];
  int m_cur_s [MAX_RUNS];
  int m_cur_e [MAX_RUNS];
  int m_cur_l [MAX_RUNS];
  int m_prev_n = 0;
  int m_cur_n = 0;
  int m_row = 0;
  int m_next = 0;
  bit m_used [MAX_OBJS];
  int m_mass [MAX_OBJS];
  int m_minx [MAX_OBJS];
  int m_maxx [MAX_OBJS];
  int m_miny [MAX_OBJS];
  int m_maxy [MAX_OBJS];

  blob_detector dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_token(in_token), .in_credit(in_credit),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last), .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int n);
    rnd_state = xorshift(rnd_state);
    return int'(rnd_state % 32'(n));
  endfunction

  function automatic logic [TOKEN_W-1:0] run_tok(input int s, input int e);
    return {1'b0, COL_W'(s), COL_W'(e)};
  endfunction

  function automatic logic [TOKEN_W-1:0] event_tok(input bit frame);
    logic [TOKEN_W-1:0] t;
    t = '0;
    t[TOK_EVENT_BIT] = 1'b1;
    t[TOK_FRAME_BIT] = frame;
    return t;
  endfunction

  function automatic void expect_word(input logic [WORD_W-1:0] w, input bit last);
    exp_q.push_back(w);
    last_q.push_back(last);
    words_exp++;
    limit += 40;
  endfunction

  // scan labels in order at frame end and drop the light ones
  function automatic void report_objects();
    int n;
    int l;
    n = 0;
    for (l = 0; l < MAX_OBJS; l++) begin
      if (m_used[l] && m_mass[l] > MIN_MASS) begin
        expect_word(32'(m_mass[l]), 1'b0);
        expect_word(32'((m_maxx[l] << 16) | m_minx[l]), 1'b0);
        expect_word(32'((m_maxy[l] << 16) | m_miny[l]), 1'b0);
        n++;
      end
      m_used[l] = 1'b0;
    end
    expect_word(32'(n), 1'b1);
    m_next = 0;
    m_row = 0;
    m_prev_n = 0;
    m_cur_n = 0;
  endfunction

  function automatic void model_token(input logic [TOKEN_W-1:0] tok);
    int s;
    int e;
    int lbl;
    int i;
    s = int'(tok[TOK_START_LSB +: COL_W]);
    e = int'(tok[COL_W-1:0]);
    if (tok[TOK_EVENT_BIT]) begin
      if (tok[TOK_FRAME_BIT]) begin
        report_objects();
      end else begin
        for (i = 0; i < m_cur_n; i++) begin
          m_prev_s[i] = m_cur_s[i];
          m_prev_e[i] = m_cur_e[i];
          m_prev_l[i] = m_cur_l[i];
        end
        m_prev_n = m_cur_n;
        m_cur_n = 0;
        m_row++;
      end
      return;
    end
    if (m_cur_n >= MAX_RUNS)
      return;  // row memory full
    lbl = -1;
    for (i = 0; i < m_prev_n; i++) begin
      if (lbl < 0 && m_prev_s[i] <= e + 1 && m_prev_e[i] + 1 >= s)
        lbl = m_prev_l[i];  // first overlap in stored order
    end
    if (lbl < 0) begin
      if (m_next >= MAX_OBJS)
        return;  // no label left so the run is lost
      lbl = m_next;
      m_next++;
      m_used[lbl] = 1'b1;
      m_mass[lbl] = e - s + 1;
      m_minx[lbl] = s;
      m_maxx[lbl] = e;
      m_miny[lbl] = m_row;
    end else begin
      m_mass[lbl] += e - s + 1;
      if (s < m_minx[lbl])
        m_minx[lbl] = s;
      if (e > m_maxx[lbl])
        m_maxx[lbl] = e;
    end
    m_maxy[lbl] = m_row;
    m_cur_s[m_cur_n] = s;
    m_cur_e[m_cur_n] = e;
    m_cur_l[m_cur_n] = lbl;
    m_cur_n++;
  endfunction

  function automatic void add_token(input logic [TOKEN_W-1:0] tok);
    tok_q.push_back(tok);
    model_token(tok);
    limit += 200;
  endfunction

  // four runs of len pixels spaced 20 columns apart
  function automatic void add_row(input int base, input int len);
    int k;
    for (k = 0; k < 4; k++)
      add_token(run_tok(base + 20 * k, base + 20 * k + len - 1));
  endfunction

  function automatic void build_random_frame();
    int rows;
    int nruns;
    int col;
    int s;
    int e;
    int r;
    int k;
    rows = 1 + rand_below(12);
    for (r = 0; r < rows; r++) begin
      nruns = rand_below(5);
      col = rand_below(8);
      for (k = 0; k < nruns; k++) begin
        s = col;
        e = s + rand_below(14);
        add_token(run_tok(s, e));
        col = e + 2 + rand_below(10);
      end
      if (r < rows - 1)
        add_token(event_tok(1'b0));
    end
    add_token(event_tok(1'b1));
  endfunction

  // 20 separate runs which overflow the label table
  function automatic void build_full_frame();
    int r;
    for (r = 0; r < 5; r++) begin
      add_row((r % 2) * 200, 9);
      if (r < 4)
        add_token(event_tok(1'b0));
    end
    add_token(event_tok(1'b1));
  endfunction

  task automatic send_token(input logic [TOKEN_W-1:0] tok);
    while (tok_sent - credit_back >= IN_DEPTH) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_token <= tok;
    tok_sent <= tok_sent + 1;
    @(posedge clk);
  endtask

  task automatic run_test(input string name);
    int err_before;
    err_before = err_cnt;
    cur_test = name;
    wait_what = "input credit";
    while (tok_q.size() != 0)
      send_token(tok_q.pop_front());
    in_valid <= 1'b0;
    wait_what = "output words";
    while (words_seen < words_exp)
      @(posedge clk);
    repeat (4) @(posedge clk);
    assert (credit_back == tok_sent) else begin
      $display("FAIL %s in_credit pulses: expected %0d actual %0d", name, tok_sent, credit_back);
      err_cnt++;
    end
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  // output checker and credit-returning sink
  always @(posedge clk) begin
    if (rst) begin
      out_cred <= OUT_CREDITS;
      out_credit <= 1'b0;
    end else begin
      out_cred <= out_cred - int'(out_valid) + int'(out_credit);
      if (in_credit)
        credit_back <= credit_back + 1;
      assert (credit_back <= tok_sent) else begin
        $display("in_credit returned %0d credits for only %0d tokens sent",
                 credit_back, tok_sent);
        err_cnt++;
      end
      if (out_valid) begin
        ret_q.push_back(cyc + sink_delay);
        words_seen <= words_seen + 1;
        if (exp_q.size() == 0) begin
          $display("%s: output word %h arrived with none expected", cur_test, out_data);
          err_cnt++;
        end else begin
          exp_w = exp_q.pop_front();
          exp_l = last_q.pop_front();
          assert (out_data == exp_w) else begin
            $display("FAIL %s word %0d: expected %h actual %h",
                     cur_test, words_seen, exp_w, out_data);
            err_cnt++;
          end
          assert (out_last == exp_l) else begin
            $display("FAIL %s last flag of word %0d: expected %0b actual %0b",
                     cur_test, words_seen, exp_l, out_last);
            err_cnt++;
          end
        end
      end
      if (ret_q.size() != 0 && ret_q[0] <= cyc) begin
        void'(ret_q.pop_front());
        out_credit <= 1'b1;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) out_valid |-> out_cred > 0)
    else begin
      $display("out_valid was high with no output credit left");
      err_cnt++;
    end

  assert property (@(posedge clk) disable iff (rst) out_last |-> out_valid)
    else begin
      $display("out_last was high without out_valid");
      err_cnt++;
    end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > limit) begin
      $display("timeout after %0d cycles in test %s waiting for %s", cyc, cur_test, wait_what);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int i;
    rst = 1'b1;
    in_valid = 1'b0;
    in_token = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    add_token(run_tok(5, 24));
    add_token(event_tok(1'b1));
    run_test("single_run");

    add_token(run_tok(10, 19));
    add_token(run_tok(40, 49));
    add_token(event_tok(1'b0));
    add_token(run_tok(20, 25));  // touches 10..19 on the diagonal
    add_token(run_tok(52, 60));  // two columns clear of 40..49
    add_token(event_tok(1'b1));
    run_test("diagonal");

    add_token(run_tok(0, 7));
    add_token(run_tok(20, 28));
    add_token(run_tok(40, 40));
    add_token(event_tok(1'b1));
    run_test("min_mass");

    sink_delay = 30;
    add_row(0, 10);
    add_token(event_tok(1'b0));
    add_row(3, 10);
    add_token(event_tok(1'b1));
    run_test("backpressure");

    // second frame queues up behind the slow report of the first
    sink_delay = 20;
    for (i = 0; i < 12; i++) begin
      add_row(0, 9);
      add_token(event_tok(1'b0));
    end
    add_token(event_tok(1'b1));
    add_row(100, 10);
    add_token(event_tok(1'b1));
    run_test("input_credit");
    sink_delay = 0;

    for (i = 0; i < 6; i++)
      build_random_frame();
    build_full_frame();
    run_test("random");

    $display("tests passed %0d failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== blob_detector.sv ====
`timescale 1ns/1ns

module blob_detector import blob_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [TOKEN_W-1:0] in_token,
  output logic               in_credit,
  output logic               out_valid,
  output logic [WORD_W-1:0]  out_data,
  output logic               out_last,
  input  logic               out_credit
);

  logic               tok_valid;
  logic [TOKEN_W-1:0] tok_data;
  logic               tok_pop;
  logic               upd_valid;
  logic               upd_new;
  logic [LABEL_W-1:0] upd_label;
  logic [COL_W-1:0]   upd_start;
  logic [COL_W-1:0]   upd_end;
  logic [ROW_W-1:0]   upd_row;
  logic               frame_end;
  logic               scan_done;
  logic               rec_ready;
  logic               rec_valid;
  logic [MASS_W-1:0]  rec_mass;
  logic [COL_W-1:0]   rec_min_x;
  logic [COL_W-1:0]   rec_max_x;
  logic [ROW_W-1:0]   rec_min_y;
  logic [ROW_W-1:0]   rec_max_y;
  logic               count_valid;
  logic [LABEL_W:0]   count;

  run_intake u_intake (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_token(in_token),
    .in_credit(in_credit), .tok_valid(tok_valid), .tok_data(tok_data), .tok_pop(tok_pop)
  );

  run_labeler u_labeler (
    .clk(clk), .rst(rst), .tok_valid(tok_valid), .tok_data(tok_data), .tok_pop(tok_pop),
    .upd_valid(upd_valid), .upd_new(upd_new), .upd_label(upd_label),
    .upd_start(upd_start), .upd_end(upd_end), .upd_row(upd_row),
    .frame_end(frame_end), .scan_done(scan_done)
  );

  object_table u_table (
    .clk(clk), .rst(rst), .upd_valid(upd_valid), .upd_new(upd_new), .upd_label(upd_label),
    .upd_start(upd_start), .upd_end(upd_end), .upd_row(upd_row),
    .frame_end(frame_end), .scan_done(scan_done), .rec_ready(rec_ready),
    .rec_valid(rec_valid), .rec_mass(rec_mass), .rec_min_x(rec_min_x),
    .rec_max_x(rec_max_x), .rec_min_y(rec_min_y), .rec_max_y(rec_max_y),
    .count_valid(count_valid), .count(count)
  );

  report_writer u_writer (
    .clk(clk), .rst(rst), .rec_valid(rec_valid), .rec_mass(rec_mass),
    .rec_min_x(rec_min_x), .rec_max_x(rec_max_x), .rec_min_y(rec_min_y),
    .rec_max_y(rec_max_y), .count_valid(count_valid), .count(count),
    .rec_ready(rec_ready), .out_valid(out_valid), .out_data(out_data),
    .out_last(out_last), .out_credit(out_credit)
  );

endmodule

// ==== report_writer.sv ====
`timescale 1ns/1ns

module report_writer import blob_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              rec_valid,
  input  logic [MASS_W-1:0] rec_mass,
  input  logic [COL_W-1:0]  rec_min_x,
  input  logic [COL_W-1:0]  rec_max_x,
  input  logic [ROW_W-1:0]  rec_min_y,
  input  logic [ROW_W-1:0]  rec_max_y,
  input  logic              count_valid,
  input  logic [LABEL_W:0]  count,
  output logic              rec_ready,
  output logic              out_valid,
  output logic [WORD_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_credit
);

  logic [WORD_W-1:0]   words [3];  // words[0] goes out next
  logic [1:0]          rem;
  logic                is_count;
  logic [CREDIT_W-1:0] credits;

  assign rec_ready = (rem == 2'd0);
  assign out_valid = (rem != 2'd0) && (credits != '0);
  assign out_data  = words[0];
  assign out_last  = out_valid && is_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      rem      <= 2'd0;
      is_count <= 1'b0;
      credits  <= CREDIT_W'(OUT_CREDITS);
    end else begin
      credits <= credits - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
      if (rec_ready) begin
        if (rec_valid) begin
          rem      <= 2'd3;
          is_count <= 1'b0;
        end else if (count_valid) begin
          rem      <= 2'd1;
          is_count <= 1'b1;
        end
      end else if (out_valid) begin
        rem <= rem - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rec_ready && rec_valid) begin
      words[0] <= WORD_W'(rec_mass);
      words[1] <= {{(WORD_W/2-COL_W){1'b0}}, rec_max_x, {(WORD_W/2-COL_W){1'b0}}, rec_min_x};
      words[2] <= {{(WORD_W/2-ROW_W){1'b0}}, rec_max_y, {(WORD_W/2-ROW_W){1'b0}}, rec_min_y};
    end else if (rec_ready && count_valid) begin
      words[0] <= WORD_W'(count);
    end else if (out_valid) begin  // shift next word up
      words[0] <= words[1];
      words[1] <= words[2];
    end
  end

endmodule

// ==== object_table.sv ====
`timescale 1ns/1ns

module object_table import blob_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               upd_valid,
  input  logic               upd_new,
  input  logic [LABEL_W-1:0] upd_label,
  input  logic [COL_W-1:0]   upd_start,
  input  logic [COL_W-1:0]   upd_end,
  input  logic [ROW_W-1:0]   upd_row,
  input  logic               frame_end,
  output logic               scan_done,
  input  logic               rec_ready,
  output logic               rec_valid,
  output logic [MASS_W-1:0]  rec_mass,
  output logic [COL_W-1:0]   rec_min_x,
  output logic [COL_W-1:0]   rec_max_x,
  output logic [ROW_W-1:0]   rec_min_y,
  output logic [ROW_W-1:0]   rec_max_y,
  output logic               count_valid,
  output logic [LABEL_W:0]   count
);

  logic [MASS_W-1:0]   mass_mem  [MAX_OBJS];
  logic [COL_W-1:0]    min_x_mem [MAX_OBJS];
  logic [COL_W-1:0]    max_x_mem [MAX_OBJS];
  logic [ROW_W-1:0]    min_y_mem [MAX_OBJS];
  logic [ROW_W-1:0]    max_y_mem [MAX_OBJS];
  logic [MAX_OBJS-1:0] used;

  logic               scanning;
  logic [LABEL_W:0]   scan_idx;
  logic [LABEL_W:0]   obj_cnt;
  logic [LABEL_W-1:0] sel;
  logic [MASS_W-1:0]  run_len;
  logic               scan_end;
  logic               reportable;
  logic               can_emit;
  logic               emit_rec;
  logic               emit_count;

  assign run_len = MASS_W'(upd_end) - MASS_W'(upd_start) + MASS_W'(1);

  assign sel        = scan_idx[LABEL_W-1:0];
  assign scan_end   = scan_idx[LABEL_W];
  assign reportable = used[sel] && (mass_mem[sel] > MASS_W'(MIN_MASS));
  // wait out the cycle in which the writer sees our last pulse
  assign can_emit   = rec_ready && !rec_valid && !count_valid;
  assign emit_rec   = scanning && !scan_end && reportable && can_emit;
  assign emit_count = scanning && scan_end && can_emit;

  // one-cycle read-modify-write per run
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      if (upd_new) begin
        mass_mem[upd_label]  <= run_len;
        min_x_mem[upd_label] <= upd_start;
        max_x_mem[upd_label] <= upd_end;
        min_y_mem[upd_label] <= upd_row;  // fixed from here on
      end else begin
        mass_mem[upd_label] <= mass_mem[upd_label] + run_len;
        if (upd_start < min_x_mem[upd_label])
          min_x_mem[upd_label] <= upd_start;
        if (upd_end > max_x_mem[upd_label])
          max_x_mem[upd_label] <= upd_end;
      end
      max_y_mem[upd_label] <= upd_row;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      used        <= '0;
      scanning    <= 1'b0;
      scan_idx    <= '0;
      obj_cnt     <= '0;
      rec_valid   <= 1'b0;
      count_valid <= 1'b0;
      scan_done   <= 1'b0;
    end else begin
      rec_valid   <= emit_rec;
      count_valid <= emit_count;
      scan_done   <= emit_count;
      if (upd_valid)
        used[upd_label] <= 1'b1;
      if (frame_end) begin
        scanning <= 1'b1;
        scan_idx <= '0;
        obj_cnt  <= '0;
      end else if (scanning) begin
        if (emit_count) begin
          scanning <= 1'b0;
          used     <= '0;  // labels restart at 0 next frame
        end else if (!scan_end && !reportable) begin
          scan_idx <= scan_idx + 1'b1;
        end else if (emit_rec) begin
          scan_idx <= scan_idx + 1'b1;
          obj_cnt  <= obj_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit_rec) begin
      rec_mass  <= mass_mem[sel];
      rec_min_x <= min_x_mem[sel];
      rec_max_x <= max_x_mem[sel];
      rec_min_y <= min_y_mem[sel];
      rec_max_y <= max_y_mem[sel];
    end
    if (emit_count)
      count <= obj_cnt;
  end

endmodule

// ==== run_labeler.sv ====
`timescale 1ns/1ns

module run_labeler import blob_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               tok_valid,
  input  logic [TOKEN_W-1:0] tok_data,
  output logic               tok_pop,
  output logic               upd_valid,
  output logic               upd_new,
  output logic [LABEL_W-1:0] upd_label,
  output logic [COL_W-1:0]   upd_start,
  output logic [COL_W-1:0]   upd_end,
  output logic [ROW_W-1:0]   upd_row,
  output logic               frame_end,
  input  logic               scan_done
);

  // two banks of runs, bank bit is the msb of the address
  logic [COL_W-1:0]   start_mem [2*MAX_RUNS];
  logic [COL_W-1:0]   end_mem   [2*MAX_RUNS];
  logic [LABEL_W-1:0] label_mem [2*MAX_RUNS];

  label_state_t       state;
  logic               bank;       // bank of the current row
  logic               flip_pend;
  logic [ROW_W-1:0]   row;
  logic [RUN_IDX_W:0] cur_cnt;
  logic [RUN_IDX_W:0] prev_cnt;
  logic [RUN_IDX_W:0] idx;
  logic [LABEL_W:0]   next_label;
  logic [COL_W-1:0]   run_start;
  logic [COL_W-1:0]   run_end;
  logic               hit;
  logic [LABEL_W-1:0] hit_label;

  logic               take;
  logic               is_event;
  logic               is_frame;
  logic               walk_done;
  logic               overlap;
  logic               store;
  logic [RUN_IDX_W:0] rd_addr;
  logic [RUN_IDX_W:0] wr_addr;
  logic [COL_W:0]     prev_start;
  logic [COL_W:0]     prev_end_p1;
  logic [COL_W:0]     cur_end_p1;

  assign is_event = tok_data[TOK_EVENT_BIT];
  assign is_frame = tok_data[TOK_FRAME_BIT];
  assign take     = tok_valid && !flip_pend && (state == idle || state == stall_full);
  assign tok_pop  = take;

  assign rd_addr = {~bank, idx[RUN_IDX_W-1:0]};
  assign wr_addr = {bank, cur_cnt[RUN_IDX_W-1:0]};

  // 8-connected test against one previous-row run
  assign prev_start  = {1'b0, start_mem[rd_addr]};
  assign prev_end_p1 = {1'b0, end_mem[rd_addr]} + 1'b1;
  assign cur_end_p1  = {1'b0, run_end} + 1'b1;
  assign overlap     = (prev_start <= cur_end_p1) && (prev_end_p1 >= {1'b0, run_start});

  assign walk_done = hit || (idx == prev_cnt);
  // stored unless a fresh label is needed and none is left
  assign store     = (state == search) && walk_done && (hit || !next_label[LABEL_W]);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= idle;
      bank       <= 1'b0;
      flip_pend  <= 1'b0;
      row        <= '0;
      cur_cnt    <= '0;
      prev_cnt   <= '0;
      next_label <= '0;
      idx        <= '0;
      hit        <= 1'b0;
      upd_valid  <= 1'b0;
      frame_end  <= 1'b0;
    end else begin
      upd_valid <= 1'b0;
      frame_end <= 1'b0;

      if (flip_pend) begin  // second cycle of a row event
        bank      <= ~bank;
        prev_cnt  <= cur_cnt;
        cur_cnt   <= '0;
        row       <= row + 1'b1;
        flip_pend <= 1'b0;
      end

      case (state)
        idle, stall_full: begin
          if (take) begin
            if (is_event) begin
              state <= is_frame ? frame_wait : idle;
              frame_end <= is_frame;
              flip_pend <= !is_frame;
            end else if (state == idle) begin
              idx   <= '0;
              hit   <= 1'b0;
              state <= search;
            end
          end
        end
        search: begin
          if (walk_done) begin
            state <= idle;
            if (store) begin
              upd_valid <= 1'b1;
              cur_cnt   <= cur_cnt + 1'b1;
              if (!hit)
                next_label <= next_label + 1'b1;
              if (cur_cnt == (RUN_IDX_W+1)'(MAX_RUNS - 1))
                state <= stall_full;
            end
          end else begin
            if (overlap)
              hit <= 1'b1;  // first overlap wins
            idx <= idx + 1'b1;
          end
        end
        frame_wait: begin
          if (scan_done) begin
            next_label <= '0;
            row        <= '0;
            cur_cnt    <= '0;
            prev_cnt   <= '0;
            state      <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take && !is_event && state == idle) begin
      run_start <= tok_data[TOK_START_LSB +: COL_W];
      run_end   <= tok_data[COL_W-1:0];
    end
    if (state == search && !walk_done && overlap)
      hit_label <= label_mem[rd_addr];
    if (store) begin
      upd_new            <= !hit;
      upd_label          <= hit ? hit_label : next_label[LABEL_W-1:0];
      upd_start          <= run_start;
      upd_end            <= run_end;
      upd_row            <= row;
      start_mem[wr_addr] <= run_start;
      end_mem[wr_addr]   <= run_end;
      label_mem[wr_addr] <= hit ? hit_label : next_label[LABEL_W-1:0];
    end
  end

endmodule

// ==== run_intake.sv ====
`timescale 1ns/1ns

module run_intake import blob_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [TOKEN_W-1:0] in_token,
  output logic               in_credit,
  output logic               tok_valid,
  output logic [TOKEN_W-1:0] tok_data,
  input  logic               tok_pop
);

  logic [TOKEN_W-1:0]  mem [IN_DEPTH];
  logic [IN_PTR_W-1:0] wr_ptr;
  logic [IN_PTR_W-1:0] rd_ptr;
  logic [IN_PTR_W:0]   fill;
  logic                pop;

  assign pop       = tok_pop && tok_valid;
  assign tok_valid = (fill != '0);
  assign tok_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill      <= fill + (IN_PTR_W+1)'(in_valid) - (IN_PTR_W+1)'(pop);
      in_credit <= pop;  // credit goes back one cycle after the pop
    end
  end

  // source never sends without credit, so no full check here
  always_ff @(posedge clk) begin
    if (in_valid)
      mem[wr_ptr] <= in_token;
  end

endmodule

// ==== blob_pkg.sv ====
package blob_pkg;

  // pixel geometry
  localparam int COL_W     = 11;
  localparam int ROW_W     = 11;
  localparam int MASS_W    = 21;

  // per-frame limits
  localparam int MAX_OBJS  = 16;
  localparam int LABEL_W   = 4;
  localparam int MAX_RUNS  = 16;
  localparam int RUN_IDX_W = 4;
  localparam int MIN_MASS  = 8;  // report only above this

  // flow control
  localparam int IN_DEPTH    = 4;
  localparam int IN_PTR_W    = 2;
  localparam int OUT_CREDITS = 4;
  localparam int CREDIT_W    = 3;

  // token layout: {event, start, end} or {event, ..., frame}
  localparam int TOKEN_W       = 23;
  localparam int TOK_EVENT_BIT = 22;
  localparam int TOK_FRAME_BIT = 0;
  localparam int TOK_START_LSB = 11;

  localparam int WORD_W = 32;

  typedef enum logic [1:0] {
    idle,
    search,
    stall_full,  // row run memory full, drop runs until row end
    frame_wait
  } label_state_t;

endpackage
